// File: Makefile
SIM   = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = alu_tile_tb
FLIST = alu_tile.f
OBJ   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)

run: compile
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf $(OBJ)

// File: alu_tile.f
verilog/alu_tile_pkg.sv
verilog/disp_alloc.sv
verilog/alu_lane.sv
verilog/rob.sv
verilog/alu_tile.sv
test/alu_tile_tb.sv

// File: test/alu_tile_tb.sv
module alu_tile_tb
  import alu_tile_pkg::*;
();

  localparam int ROB_SIZE = 8;
  // Room for 440 instructions and three drains under random ready
  localparam int MAX_CYCLES = 4000;

  logic       i_clk;
  logic       i_rst;
  logic       i_disp_valid;
  disp_inst_t i_disp;
  logic       o_disp_ready;
  logic       o_cmt_valid;
  cmt_t       o_cmt;
  logic       i_cmt_ready;

  integer     seed;
  int         cyc;
  int         ready_mode;
  int         hold_cycles;
  logic       mul_phase;
  logic       saw_full;
  tag_t       next_tag;

  // Reference model state
  cmt_t       exp_q [$];
  cmt_t       exp_head;
  int         exp_cnt;

  alu_tile i_alu_tile (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_disp_valid (i_disp_valid),
    .i_disp       (i_disp),
    .o_disp_ready (o_disp_ready),
    .o_cmt_valid  (o_cmt_valid),
    .o_cmt        (o_cmt),
    .i_cmt_ready  (i_cmt_ready)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // Expected result straight from the opcode rules
  function automatic xlen_t ref_result(input alu_op_e op, input xlen_t a, input xlen_t b);
    logic [63:0] prod;
    prod = {32'b0, a} * {32'b0, b};
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[4:0];
      OP_MUL:  return prod[31:0];
      default: return '0;
    endcase
  endfunction

  // --------------------
  // Reference queue
  // --------------------
  always @(posedge i_clk) begin
    if (!i_rst) begin
      if (mul_phase && !o_disp_ready && exp_cnt == ROB_SIZE) begin
        saw_full = 1'b1;
      end
      if (o_cmt_valid && i_cmt_ready && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
      end
      if (i_disp_valid && o_disp_ready) begin
        exp_q.push_back('{tag: i_disp.tag,
                          result: ref_result(i_disp.op, i_disp.src1, i_disp.src2)});
      end
    end
    exp_cnt  = exp_q.size();
    exp_head = (exp_cnt != 0) ? exp_q[0] : '0;
  end

  always @(posedge i_clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      fail_run("Timeout, the run did not finish within the cycle limit");
    end
  end

  // --------------------
  // Checks
  // --------------------
  a_cmt_expected: assert property (@(posedge i_clk) disable iff (i_rst)
    o_cmt_valid && i_cmt_ready |-> exp_cnt != 0)
    else fail_run("A commit left the tile with no instruction outstanding");

  a_cmt_tag: assert property (@(posedge i_clk) disable iff (i_rst)
    o_cmt_valid && i_cmt_ready |-> o_cmt.tag == exp_head.tag)
    else fail_run($sformatf("ERR o_cmt.tag got %h expected %h",
                            $sampled(o_cmt.tag), $sampled(exp_head.tag)));

  a_cmt_result: assert property (@(posedge i_clk) disable iff (i_rst)
    o_cmt_valid && i_cmt_ready |-> o_cmt.result == exp_head.result)
    else fail_run($sformatf("ERR o_cmt.result got %h expected %h",
                            $sampled(o_cmt.result), $sampled(exp_head.result)));

  // Payload held while the sink stalls
  a_cmt_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_cmt_valid && !i_cmt_ready |=> o_cmt_valid && $stable(o_cmt))
    else fail_run($sformatf("ERR o_cmt changed under back-pressure, now %h valid %h",
                            $sampled(o_cmt), $sampled(o_cmt_valid)));

  a_in_flight: assert property (@(posedge i_clk) disable iff (i_rst)
    exp_cnt <= ROB_SIZE)
    else fail_run($sformatf("ERR in-flight count %h above limit %h",
                            $sampled(exp_cnt), ROB_SIZE));

  a_reset_quiet: assert property (@(posedge i_clk)
    (cyc > 0) && (i_rst || $past(i_rst)) |-> !o_cmt_valid)
    else fail_run($sformatf("ERR o_cmt_valid %h during or right after reset",
                            $sampled(o_cmt_valid)));

  // --------------------
  // Stimulus
  // --------------------
  task automatic drive_ready();
    case (ready_mode)
      0: i_cmt_ready = 1'b1;
      1: i_cmt_ready = ($random(seed) % 4) != 0;
      default: begin
        if (hold_cycles > 0) begin
          i_cmt_ready = 1'b0;
          hold_cycles--;
        end else begin
          i_cmt_ready = 1'b1;
        end
      end
    endcase
  endtask

  task automatic next_cycle();
    @(posedge i_clk);
    #1;
    drive_ready();
  endtask

  // Ready only moves with registered state, so its value here holds to the edge
  task automatic send_inst(input alu_op_e op, input xlen_t a, input xlen_t b);
    logic taken;
    i_disp_valid = 1'b1;
    i_disp       = '{op: op, src1: a, src2: b, tag: next_tag};
    taken        = 1'b0;
    while (!taken) begin
      taken = o_disp_ready;
      next_cycle();
    end
    i_disp_valid = 1'b0;
    next_tag     = next_tag + 8'd1;
  endtask

  task automatic send_random(input int count, input logic mul_heavy);
    alu_op_e op;
    for (int n = 0; n < count; n++) begin
      op = alu_op_e'({$random(seed)} % 7);
      if (mul_heavy && ({$random(seed)} % 4) != 0) begin
        op = OP_MUL;
      end
      send_inst(op, $random(seed), $random(seed));
    end
  endtask

  task automatic drain();
    while (exp_cnt != 0) begin
      next_cycle();
    end
  endtask

  initial begin
    seed         = 32'h4170279c;
    cyc          = 0;
    ready_mode   = 0;
    hold_cycles  = 0;
    mul_phase    = 1'b0;
    saw_full     = 1'b0;
    next_tag     = '0;
    exp_cnt      = 0;
    exp_head     = '0;
    i_rst        = 1'b1;
    i_disp_valid = 1'b0;
    i_disp       = '0;
    i_cmt_ready  = 1'b0;

    repeat (8) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    drive_ready();

    // Free-flowing sink
    send_random(200, 1'b0);
    drain();

    ready_mode = 1;
    send_random(200, 1'b0);
    drain();

    // Multiply-heavy burst against a stalled sink
    ready_mode  = 2;
    hold_cycles = 30;
    mul_phase   = 1'b1;
    drive_ready();
    send_random(40, 1'b1);
    drain();
    repeat (8) next_cycle();

    if (o_cmt_valid) begin
      fail_run("A commit was still pending after every instruction had drained");
    end else if (!saw_full) begin
      fail_run("Dispatch never stalled on a full reorder buffer");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

// File: verilog/alu_lane.sv
module alu_lane
  import alu_tile_pkg::*;
#(
  parameter int RS_DEPTH = 4
) (
  input  logic      i_clk,
  input  logic      i_rst,

  input  logic      i_issue_valid,
  input  issue_t    i_issue,

  output logic      o_credit_ret,
  output done_rpt_t o_done
);

  localparam int MUL_LAT   = 3;
  localparam int RS_W      = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
  localparam int RS_CNT_W  = $clog2(RS_DEPTH + 1);
  localparam int MUL_CNT_W = $clog2(MUL_LAT);

  // Reservation station
  issue_t              r_rs [RS_DEPTH];
  logic [RS_W-1:0]     r_rs_head;
  logic [RS_W-1:0]     r_rs_tail;
  logic [RS_CNT_W-1:0] r_rs_cnt;
  issue_t              w_head;
  logic                w_pop;
  logic                w_is_mul;

  // Execute stage
  xlen_t               w_alu_res;
  xlen_t               w_mul_prod;
  logic                r_mul_busy;
  logic [MUL_CNT_W-1:0] r_mul_cnt;
  cmt_id_t             r_mul_id;
  xlen_t               r_mul_res;
  logic                r_done_valid;
  cmt_id_t             r_done_id;
  xlen_t               r_done_res;

  // --------------------
  // Station
  // --------------------
  assign w_head   = r_rs[r_rs_head];
  assign w_is_mul = (w_head.inst.op == OP_MUL);

  // Oldest entry leaves once the multiplier is idle
  assign w_pop = (r_rs_cnt != '0) && !r_mul_busy;

  always_ff @(posedge i_clk) begin
    if (i_issue_valid) begin
      r_rs[r_rs_tail] <= i_issue;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_rs_head <= '0;
      r_rs_tail <= '0;
      r_rs_cnt  <= '0;
    end else begin
      if (i_issue_valid) begin
        r_rs_tail <= (r_rs_tail == RS_W'(RS_DEPTH - 1)) ? '0 : r_rs_tail + 1'b1;
      end
      if (w_pop) begin
        r_rs_head <= (r_rs_head == RS_W'(RS_DEPTH - 1)) ? '0 : r_rs_head + 1'b1;
      end
      r_rs_cnt <= r_rs_cnt + RS_CNT_W'(i_issue_valid) - RS_CNT_W'(w_pop);
    end
  end

  // --------------------
  // Execute
  // --------------------
  assign w_mul_prod = w_head.inst.src1 * w_head.inst.src2;

  always_comb begin
    case (w_head.inst.op)
      OP_ADD:  w_alu_res = w_head.inst.src1 + w_head.inst.src2;
      OP_SUB:  w_alu_res = w_head.inst.src1 - w_head.inst.src2;
      OP_AND:  w_alu_res = w_head.inst.src1 & w_head.inst.src2;
      OP_OR:   w_alu_res = w_head.inst.src1 | w_head.inst.src2;
      OP_XOR:  w_alu_res = w_head.inst.src1 ^ w_head.inst.src2;
      OP_SLL:  w_alu_res = w_head.inst.src1 << w_head.inst.src2[4:0];
      default: w_alu_res = w_mul_prod;
    endcase
  end

  // Multiply holds the stage until the count runs out
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_mul_busy   <= 1'b0;
      r_mul_cnt    <= '0;
      r_done_valid <= 1'b0;
      o_credit_ret <= 1'b0;
    end else begin
      o_credit_ret <= w_pop;
      r_done_valid <= (w_pop && !w_is_mul) ||
                      (r_mul_busy && (r_mul_cnt == MUL_CNT_W'(1)));
      if (w_pop && w_is_mul) begin
        r_mul_busy <= 1'b1;
        r_mul_cnt  <= MUL_CNT_W'(MUL_LAT - 1);
      end else if (r_mul_busy) begin
        r_mul_cnt <= r_mul_cnt - 1'b1;
        if (r_mul_cnt == MUL_CNT_W'(1)) begin
          r_mul_busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_pop && w_is_mul) begin
      r_mul_id  <= w_head.cmt_id;
      r_mul_res <= w_mul_prod;
    end
    if (r_mul_busy) begin
      r_done_id  <= r_mul_id;
      r_done_res <= r_mul_res;
    end else if (w_pop) begin
      r_done_id  <= w_head.cmt_id;
      r_done_res <= w_alu_res;
    end
  end

  assign o_done = '{valid: r_done_valid, cmt_id: r_done_id, result: r_done_res};

  // Allocator credits must keep the station from overflowing
  a_no_issue_when_full: assert property (@(posedge i_clk) disable iff (i_rst)
    i_issue_valid |-> (r_rs_cnt != RS_CNT_W'(RS_DEPTH)));

endmodule

// File: verilog/alu_tile.sv
module alu_tile
  import alu_tile_pkg::*;
#(
  parameter int LANE_NUM = 2,
  parameter int RS_DEPTH = 4,
  parameter int ROB_SIZE = 8
) (
  input  logic       i_clk,
  input  logic       i_rst,

  input  logic       i_disp_valid,
  input  disp_inst_t i_disp,
  output logic       o_disp_ready,

  output logic       o_cmt_valid,
  output cmt_t       o_cmt,
  input  logic       i_cmt_ready
);

  // --------------------
  // Internal wires
  // --------------------
  logic [LANE_NUM-1:0] w_issue_valid;
  issue_t              w_issue;
  logic [LANE_NUM-1:0] w_lane_credit_ret;
  logic                w_rob_credit_ret;
  logic                w_alloc_valid;
  cmt_id_t             w_alloc_id;
  tag_t                w_alloc_tag;
  done_rpt_t           w_done [LANE_NUM];

  disp_alloc #(
    .LANE_NUM (LANE_NUM),
    .RS_DEPTH (RS_DEPTH),
    .ROB_SIZE (ROB_SIZE)
  ) u_disp_alloc (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_disp_valid      (i_disp_valid),
    .i_disp            (i_disp),
    .o_disp_ready      (o_disp_ready),
    .o_issue_valid     (w_issue_valid),
    .o_issue           (w_issue),
    .i_lane_credit_ret (w_lane_credit_ret),
    .i_rob_credit_ret  (w_rob_credit_ret),
    .o_alloc_valid     (w_alloc_valid),
    .o_alloc_id        (w_alloc_id),
    .o_alloc_tag       (w_alloc_tag)
  );

  // All lanes see the same issue payload, the valid bit picks one
  for (genvar l = 0; l < LANE_NUM; l++) begin : g_lane
    alu_lane #(
      .RS_DEPTH (RS_DEPTH)
    ) u_alu_lane (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_issue_valid (w_issue_valid[l]),
      .i_issue       (w_issue),
      .o_credit_ret  (w_lane_credit_ret[l]),
      .o_done        (w_done[l])
    );
  end

  rob #(
    .LANE_NUM (LANE_NUM),
    .ROB_SIZE (ROB_SIZE)
  ) u_rob (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_alloc_valid (w_alloc_valid),
    .i_alloc_id    (w_alloc_id),
    .i_alloc_tag   (w_alloc_tag),
    .i_done        (w_done),
    .o_credit_ret  (w_rob_credit_ret),
    .o_cmt_valid   (o_cmt_valid),
    .o_cmt         (o_cmt),
    .i_cmt_ready   (i_cmt_ready)
  );

endmodule

// File: verilog/alu_tile_pkg.sv
package alu_tile_pkg;

  // --------------------
  // Widths
  // --------------------

  // Operand and result width
  localparam int XLEN = 32;

  // Commit ID width, covers a ROB of up to 16 entries
  localparam int CMT_ID_W = 4;

  localparam int TAG_W = 8;

  typedef logic [XLEN-1:0]     xlen_t;
  typedef logic [CMT_ID_W-1:0] cmt_id_t;
  typedef logic [TAG_W-1:0]    tag_t;

  // --------------------
  // Opcodes
  // --------------------

  // SLL shifts by src2[4:0], MUL keeps the low half of the product
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SLL = 3'd5,
    OP_MUL = 3'd6
  } alu_op_e;

  // --------------------
  // Bundles
  // --------------------

  // Instruction as it arrives from the dispatch source
  typedef struct packed {
    alu_op_e op;
    xlen_t   src1;
    xlen_t   src2;
    tag_t    tag;
  } disp_inst_t;

  // Allocator to lane
  typedef struct packed {
    disp_inst_t inst;
    cmt_id_t    cmt_id;
  } issue_t;

  // Lane to ROB
  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
    xlen_t   result;
  } done_rpt_t;

  // Commit port payload
  typedef struct packed {
    tag_t  tag;
    xlen_t result;
  } cmt_t;

endpackage

// File: verilog/disp_alloc.sv
module disp_alloc
  import alu_tile_pkg::*;
#(
  parameter int LANE_NUM = 2,
  parameter int RS_DEPTH = 4,
  parameter int ROB_SIZE = 8
) (
  input  logic                i_clk,
  input  logic                i_rst,

  // Dispatch from the source
  input  logic                i_disp_valid,
  input  disp_inst_t          i_disp,
  output logic                o_disp_ready,

  // Issue to the lanes
  output logic [LANE_NUM-1:0] o_issue_valid,
  output issue_t              o_issue,

  // Credit returns
  input  logic [LANE_NUM-1:0] i_lane_credit_ret,
  input  logic                i_rob_credit_ret,

  // Allocation notice to the ROB
  output logic                o_alloc_valid,
  output cmt_id_t             o_alloc_id,
  output tag_t                o_alloc_tag
);

  localparam int LANE_W    = (LANE_NUM > 1) ? $clog2(LANE_NUM) : 1;
  localparam int RS_CNT_W  = $clog2(RS_DEPTH + 1);
  localparam int ROB_CNT_W = $clog2(ROB_SIZE + 1);

  logic [LANE_NUM-1:0]  w_lane_has_credit;
  logic [LANE_NUM-1:0]  w_lane_sel;
  logic [ROB_CNT_W-1:0] r_rob_cnt;
  logic [LANE_W-1:0]    r_lane_ptr;
  cmt_id_t              r_next_id;
  logic                 w_accept;

  // Waits on the lane the pointer names, never skips ahead
  assign o_disp_ready = (r_rob_cnt != '0) && w_lane_has_credit[r_lane_ptr];
  assign w_accept     = i_disp_valid && o_disp_ready;
  assign w_lane_sel   = LANE_NUM'(1) << r_lane_ptr;

  // --------------------
  // Lane credits
  // --------------------
  for (genvar l = 0; l < LANE_NUM; l++) begin : g_lane_cnt
    logic [RS_CNT_W-1:0] r_cnt;
    logic                w_take;

    assign w_take               = w_accept && w_lane_sel[l];
    assign w_lane_has_credit[l] = (r_cnt != '0);

    always_ff @(posedge i_clk) begin
      if (i_rst) begin
        r_cnt <= RS_CNT_W'(RS_DEPTH);
      end else begin
        r_cnt <= r_cnt - RS_CNT_W'(w_take) + RS_CNT_W'(i_lane_credit_ret[l]);
      end
    end

    // A lane never returns more entries than it was given
    a_lane_cnt_max: assert property (@(posedge i_clk) disable iff (i_rst)
      r_cnt <= RS_CNT_W'(RS_DEPTH));
  end

  // --------------------
  // ROB credits
  // --------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_rob_cnt <= ROB_CNT_W'(ROB_SIZE);
    end else begin
      r_rob_cnt <= r_rob_cnt - ROB_CNT_W'(w_accept) + ROB_CNT_W'(i_rob_credit_ret);
    end
  end

  // --------------------
  // Lane pointer, IDs
  // --------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_lane_ptr    <= '0;
      r_next_id     <= '0;
      o_issue_valid <= '0;
      o_alloc_valid <= 1'b0;
    end else begin
      o_issue_valid <= w_accept ? w_lane_sel : '0;
      o_alloc_valid <= w_accept;
      if (w_accept) begin
        r_lane_ptr <= (r_lane_ptr == LANE_W'(LANE_NUM - 1)) ? '0 : r_lane_ptr + 1'b1;
        // Wraps at the ROB size
        r_next_id  <= (r_next_id == CMT_ID_W'(ROB_SIZE - 1)) ? '0 : r_next_id + 1'b1;
      end
    end
  end

  // Issue and allocation payload
  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      o_issue.inst   <= i_disp;
      o_issue.cmt_id <= r_next_id;
      o_alloc_id     <= r_next_id;
      o_alloc_tag    <= i_disp.tag;
    end
  end

  a_rob_cnt_max: assert property (@(posedge i_clk) disable iff (i_rst)
    r_rob_cnt <= ROB_CNT_W'(ROB_SIZE));

  a_issue_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
    $onehot0(o_issue_valid));

endmodule

// File: verilog/rob.sv
module rob
  import alu_tile_pkg::*;
#(
  parameter int LANE_NUM = 2,
  parameter int ROB_SIZE = 8
) (
  input  logic      i_clk,
  input  logic      i_rst,

  // Allocation from the dispatcher
  input  logic      i_alloc_valid,
  input  cmt_id_t   i_alloc_id,
  input  tag_t      i_alloc_tag,

  // Done reports, one per lane
  input  done_rpt_t i_done [LANE_NUM],

  output logic      o_credit_ret,

  // Commit port
  output logic      o_cmt_valid,
  output cmt_t      o_cmt,
  input  logic      i_cmt_ready
);

  localparam int ROB_W = (ROB_SIZE > 1) ? $clog2(ROB_SIZE) : 1;

  logic [ROB_SIZE-1:0] r_busy;
  logic [ROB_SIZE-1:0] r_cmpl;
  tag_t                r_tag [ROB_SIZE];
  xlen_t               r_res [ROB_SIZE];
  logic [ROB_W-1:0]    r_head;
  logic [ROB_W-1:0]    r_tail;
  logic [ROB_W-1:0]    w_alloc_idx;
  logic                w_out_free;
  logic                w_head_go;

  assign w_alloc_idx = i_alloc_id[ROB_W-1:0];

  // Output register is empty or drains this cycle
  assign w_out_free = !o_cmt_valid || i_cmt_ready;
  assign w_head_go  = r_busy[r_head] && r_cmpl[r_head] && w_out_free;

  // --------------------
  // Entry state
  // --------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_busy       <= '0;
      r_cmpl       <= '0;
      r_head       <= '0;
      r_tail       <= '0;
      o_cmt_valid  <= 1'b0;
      o_credit_ret <= 1'b0;
    end else begin
      // Credit goes back only once the sink has taken the result
      o_credit_ret <= o_cmt_valid && i_cmt_ready;

      if (w_head_go) begin
        r_busy[r_head] <= 1'b0;
        r_cmpl[r_head] <= 1'b0;
        r_head         <= r_head + 1'b1;
        o_cmt_valid    <= 1'b1;
      end else if (i_cmt_ready) begin
        o_cmt_valid <= 1'b0;
      end

      for (int l = 0; l < LANE_NUM; l++) begin
        if (i_done[l].valid) begin
          r_cmpl[i_done[l].cmt_id[ROB_W-1:0]] <= 1'b1;
        end
      end

      if (i_alloc_valid) begin
        r_busy[w_alloc_idx] <= 1'b1;
        r_cmpl[w_alloc_idx] <= 1'b0;
        r_tail              <= r_tail + 1'b1;
      end
    end
  end

  // --------------------
  // Payload
  // --------------------
  always_ff @(posedge i_clk) begin
    if (i_alloc_valid) begin
      r_tag[w_alloc_idx] <= i_alloc_tag;
    end
    for (int l = 0; l < LANE_NUM; l++) begin
      if (i_done[l].valid) begin
        r_res[i_done[l].cmt_id[ROB_W-1:0]] <= i_done[l].result;
      end
    end
    if (w_head_go) begin
      o_cmt <= '{tag: r_tag[r_head], result: r_res[r_head]};
    end
  end

  // --------------------
  // Checks
  // --------------------
  for (genvar l = 0; l < LANE_NUM; l++) begin : g_done_chk
    a_done_target: assert property (@(posedge i_clk) disable iff (i_rst)
      i_done[l].valid |-> r_busy[i_done[l].cmt_id[ROB_W-1:0]] &&
                          !r_cmpl[i_done[l].cmt_id[ROB_W-1:0]]);
  end

  // IDs arrive in order and never land on a live entry
  a_alloc_in_order: assert property (@(posedge i_clk) disable iff (i_rst)
    i_alloc_valid |-> (w_alloc_idx == r_tail) && !r_busy[w_alloc_idx]);

  a_cmt_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    o_cmt_valid && !i_cmt_ready |=> o_cmt_valid && $stable(o_cmt));

endmodule
